//--- bench/mbu_assert.sv
////////////////////////////////////////
// MBU protocol and output checks, bound
// into the top level
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module mbu_assert (
   input logic                             clk,
   input logic                             reset,
   input mbu_bus_pkg::apb_req_t            apb_req,
   input mbu_bus_pkg::apb_rsp_t            apb_rsp,
   input logic [mbu_pkg::ucode_addr_w-1:0] raddr,
   input logic [mbu_pkg::ucode_addr_w-1:0] waddr,
   input logic                             wstb,
   input logic [11:0]                      ir,
   input logic                             fprom,
   input logic [7:0]                       aext,
   input logic                             ibus_oe,
   input logic                             write_flags,
   input mbu_bus_pkg::bank_wr_t            bank_wr
);

   import mbu_pkg::*;

   // Failures seen so far, read by the testbench
   int   fail_count = 0;
   // Any edge that can change bank state
   logic wr_any;
   // Address outside the bank register window
   logic miss;

   assign wr_any = bank_wr.valid |
                   (wstb & ((waddr == waddr_mbp) | (waddr == waddr_ar_mbx)));

   assign miss = (apb_req.paddr < io_base) ||
                 (apb_req.paddr > io_base + 8'(num_banks - 1));

   // Error only in the access phase of a miss
   pslverr_in_access: assert property (@(posedge clk) disable iff (reset)
      apb_rsp.pslverr |-> (apb_req.psel & apb_req.penable & miss))
   else begin
      $error("pslverr raised outside an APB access phase to a missing address");
      fail_count++;
   end

   // Bus driven only by the pointer read code
   oe_from_read_mbp: assert property (@(posedge clk) disable iff (reset)
      ibus_oe |-> (raddr == raddr_mbp))
   else begin
      $error("ibus_oe high without the pointer read code");
      fail_count++;
   end

   // External flag write needs the write strobe and the flags code
   wflags_needs_wstb: assert property (@(posedge clk) disable iff (reset)
      write_flags |-> (wstb && (waddr == waddr_flags)))
   else begin
      $error("write_flags high without wstb and the flags write code");
      fail_count++;
   end

   // No write, same select inputs, same extended address
   aext_holds: assert property (@(posedge clk) disable iff (reset)
      (!$past(reset) && !$past(wr_any) && $stable(ir) && $stable(fprom)) |-> $stable(aext))
   else begin
      $error("aext changed without a write or a select change");
      fail_count++;
   end

endmodule : mbu_assert

`default_nettype wire

//--- bench/mbu_tb.sv
////////////////////////////////////////
// MBU testbench. Drives APB and microcode
// ports, keeps a bank model, reports per test
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module mbu_tb;

   import mbu_pkg::*;
   import mbu_bus_pkg::*;

   localparam int half_period     = 20;
   localparam int period          = 2 * half_period;
   // Sample point after a falling-edge drive
   localparam int settle          = 5;
   localparam int num_tests       = 6;
   localparam int cycles_per_test = 200;

   logic                    clk;
   logic                    reset;
   apb_req_t                apb_req;
   apb_rsp_t                apb_rsp;
   logic [ucode_addr_w-1:0] raddr;
   logic [ucode_addr_w-1:0] waddr;
   logic                    wstb;
   logic [11:0]             ir;
   logic [bank_w-1:0]       ibus_in;
   logic [bank_w-1:0]       ibus_out;
   logic                    ibus_oe;
   logic                    fprom;
   logic [bank_w-1:0]       aext;
   logic                    read_flags;
   logic                    write_flags;

   // Expected bank contents
   logic [bank_w-1:0] model [num_banks];
   integer            seed;
   int                errors;
   int                errors_at_start;
   int                test_no;
   int                tests_failed;
   // Outputs captured by the last micro_op
   logic [bank_w-1:0] op_bus;
   logic              op_oe;
   logic              op_rflags;
   logic              op_wflags;

   mbu_top mbu_top_i (.*);

   bind mbu_top mbu_assert mbu_assert_i (
      .clk         (clk),
      .reset       (reset),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .raddr       (raddr),
      .waddr       (waddr),
      .wstb        (wstb),
      .ir          (ir),
      .fprom       (fprom),
      .aext        (aext),
      .ibus_oe     (ibus_oe),
      .write_flags (write_flags),
      .bank_wr     (bank_wr)
   );

   always #half_period clk = ~clk;

   ////////////////////////////////////////
   // Checks and reporting
   ////////////////////////////////////////

   task automatic check_byte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
      assert (actual === expected) else begin
         $display("FAILED at %0t ns: %s expected 0x%02h, got 0x%02h",
                  $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      assert (actual === expected) else begin
         $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
         errors++;
      end
   endtask

   // Counts both testbench checks and bound assertion failures
   task automatic end_test(input string name);
      int total;
      total = errors + mbu_top_i.mbu_assert_i.fail_count;
      test_no++;
      if (total == errors_at_start) begin
         $display("[%0d] %s: pass", test_no, name);
      end else begin
         tests_failed++;
         $display("[%0d] %s: fail, %0d errors", test_no, name, total - errors_at_start);
      end
      errors_at_start = total;
   endtask

   function automatic logic [7:0] random_byte();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // Setup, then access, then idle; err is pslverr in the access phase
   task automatic apb_write(input logic [7:0] addr, input logic [7:0] data, output logic err);
      @(negedge clk);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b1;
      apb_req.paddr   = addr;
      apb_req.pwdata  = data;
      @(negedge clk);
      apb_req.penable = 1'b1;
      #settle;
      err = apb_rsp.pslverr;
      check_bit("pready", 1'b1, apb_rsp.pready);
      @(negedge clk);
      apb_req = '0;
      #settle;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [7:0] data, output logic err);
      @(negedge clk);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b0;
      apb_req.paddr   = addr;
      @(negedge clk);
      apb_req.penable = 1'b1;
      #settle;
      data = apb_rsp.prdata;
      err  = apb_rsp.pslverr;
      check_bit("pready", 1'b1, apb_rsp.pready);
      @(negedge clk);
      apb_req = '0;
      #settle;
   endtask

   // One microcode cycle, then idle codes
   task automatic micro_op(input logic [4:0] ra, input logic [4:0] wa, input logic stb,
                           input logic [7:0] data);
      @(negedge clk);
      raddr   = ra;
      waddr   = wa;
      wstb    = stb;
      ibus_in = data;
      #settle;
      op_bus    = ibus_out;
      op_oe     = ibus_oe;
      op_rflags = read_flags;
      op_wflags = write_flags;
      @(negedge clk);
      raddr   = '0;
      waddr   = '0;
      wstb    = 1'b0;
      ibus_in = '0;
      #settle;
   endtask

   // APB readback of the whole window against the model
   task automatic compare_all_banks();
      logic [7:0] data;
      logic       err;
      for (int i = 0; i < num_banks; i++) begin
         apb_read(io_base | 8'(i), data, err);
         check_bit("pslverr", 1'b0, err);
         check_byte("prdata", model[i], data);
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin
      logic       err;
      logic [7:0] data;
      logic [7:0] r;
      int         idx;
      logic [7:0] bad_addr [4];
      bad_addr = '{8'h00, 8'h07, 8'h10, 8'hff};
      seed     = 32'h7d960d0b;
      errors          = 0;
      errors_at_start = 0;
      test_no         = 0;
      tests_failed    = 0;
      clk     = 1'b0;
      reset   = 1'b1;
      apb_req = '0;
      raddr   = '0;
      waddr   = '0;
      wstb    = 1'b0;
      ir      = '0;
      ibus_in = '0;
      fprom   = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      #settle;

      // Reset state and power-on extended address
      check_byte("aext", default_rom, aext);
      check_bit("read_flags", 1'b0, read_flags);
      check_bit("write_flags", 1'b0, write_flags);
      check_bit("ibus_oe", 1'b0, ibus_oe);
      check_bit("pslverr", 1'b0, apb_rsp.pslverr);
      @(negedge clk);
      fprom = 1'b0;
      #settle;
      check_byte("aext", 8'h00, aext);
      // Micro-writes do not wake the registers
      micro_op('0, waddr_ar_mbx, 1'b1, 8'h5a);
      check_byte("aext", 8'h00, aext);
      @(negedge clk);
      fprom = 1'b1;
      ir    = 12'h800;
      micro_op('0, waddr_mbp, 1'b1, 8'h06);
      check_byte("aext", default_rom, aext);
      end_test("power-on default");

      // Fill the window, aext shows each write one cycle later
      for (int i = 0; i < num_banks; i++) begin
         @(negedge clk);
         ir       = {1'b1, 8'h00, 3'(i)};
         model[i] = random_byte();
         apb_write(io_base | 8'(i), model[i], err);
         check_bit("pslverr", 1'b0, err);
         check_byte("aext", model[i], aext);
      end
      compare_all_banks();
      end_test("apb write and readback");

      // Outside the window
      for (int i = 0; i < 4; i++) begin
         apb_write(bad_addr[i], random_byte(), err);
         check_bit("pslverr", 1'b1, err);
         apb_read(bad_addr[i], data, err);
         check_bit("pslverr", 1'b1, err);
         check_byte("prdata", 8'h00, data);
      end
      compare_all_banks();
      end_test("address errors");

      // Bank pointer write, read on the internal bus
      @(negedge clk);
      ir = '0;
      for (int p = 0; p < num_banks; p++) begin
         r = random_byte();
         micro_op('0, waddr_mbp, 1'b1, {r[7:3], 3'(p)});
         micro_op(raddr_mbp, '0, 1'b0, 8'h00);
         check_byte("ibus_out", {5'b0, 3'(p)}, op_bus);
         check_bit("ibus_oe", 1'b1, op_oe);
         check_byte("aext", model[p], aext);
      end
      end_test("bank pointer");

      // Micro register write through ir[2:0]
      for (int i = 0; i < 4; i++) begin
         idx = int'(random_byte()) % num_banks;
         @(negedge clk);
         ir = {1'b1, 8'h00, 3'(idx)};
         r  = random_byte();
         micro_op('0, waddr_ar_mbx, 1'b1, r);
         model[idx] = r;
         check_byte("aext", r, aext);
         micro_op('0, waddr_ar_mbx, 1'b0, ~r);
         check_byte("aext", model[idx], aext);
      end
      // And through the pointer, left at 7
      @(negedge clk);
      ir = '0;
      r  = random_byte();
      micro_op('0, waddr_ar_mbx, 1'b1, r);
      model[7] = r;
      check_byte("aext", r, aext);
      compare_all_banks();
      end_test("micro register write");

      // Flag unit strobes
      micro_op(raddr_flags, '0, 1'b0, 8'h00);
      check_bit("read_flags", 1'b1, op_rflags);
      check_bit("write_flags", 1'b0, op_wflags);
      check_bit("ibus_oe", 1'b0, op_oe);
      micro_op('0, waddr_flags, 1'b0, 8'h00);
      check_bit("read_flags", 1'b0, op_rflags);
      check_bit("write_flags", 1'b0, op_wflags);
      micro_op('0, waddr_flags, 1'b1, 8'h00);
      check_bit("write_flags", 1'b1, op_wflags);
      micro_op('0, '0, 1'b1, 8'h00);
      check_bit("write_flags", 1'b0, op_wflags);
      end_test("flag strobes");

      $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
               test_no, tests_failed, errors, mbu_top_i.mbu_assert_i.fail_count);
      if (errors == 0 && mbu_top_i.mbu_assert_i.fail_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // Watchdog, sized from the number of tests
   initial begin
      #(num_tests * cycles_per_test * period);
      $display("Watchdog expired after %0d cycles", num_tests * cycles_per_test);
      $display("Test FAILED");
      $finish;
   end

endmodule : mbu_tb

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the MBU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module mbu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Error limit raised so assertion failures reach the end-of-run summary
out=$(./obj_dir/Vmbu_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
   exit 0
fi
exit 1

//--- src.f
verilog/mbu_pkg.sv
verilog/mbu_bus_pkg.sv
verilog/mbu_ucode_decode.sv
verilog/mbu_io_port.sv
verilog/mbu_bank_file.sv
verilog/mbu_top.sv
bench/mbu_assert.sv
bench/mbu_tb.sv

//--- verilog/mbu_bank_file.sv
////////////////////////////////////////
// MBU bank register file. Eight bank
// registers, bank pointer, power-on
// default and extended address select
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module mbu_bank_file (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        wstb,
   input  mbu_bus_pkg::ucode_strobe_t  strobe,
   input  mbu_bus_pkg::bank_wr_t       bank_wr,
   input  mbu_bus_pkg::bank_rd_t       bank_rd,
   output logic [mbu_pkg::bank_w-1:0]  bank_rdata,
   input  logic [11:0]                 ir,
   input  logic [mbu_pkg::bank_w-1:0]  ibus_in,
   output logic [mbu_pkg::bank_w-1:0]  ibus_out,
   output logic                        ibus_oe,
   input  logic                        fprom,
   output logic [mbu_pkg::bank_w-1:0]  aext
);

   import mbu_pkg::*;
   import mbu_bus_pkg::*;

   logic [bank_w-1:0]     mb [num_banks];
   logic [bank_idx_w-1:0] mbp;
   logic                  dis;
   logic [bank_idx_w-1:0] act_idx;
   logic                  uwr_mbp;
   logic                  uwr_mbx;

   ////////////////////////////////////////
   // Active register select
   ////////////////////////////////////////

   // IR bit 11 means the instruction names the bank itself
   // Otherwise the bank pointer picks it
   assign act_idx = ir[11] ? ir[bank_idx_w-1:0] : mbp;

   // Micro-writes land only on a wstb edge
   assign uwr_mbp = wstb & strobe.write_mbp;
   assign uwr_mbx = wstb & strobe.write_ar_mbx;

   ////////////////////////////////////////
   // Control state
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         mbp <= '0;
         dis <= 1'b1;
      end else begin
         if (uwr_mbp) begin
            mbp <= ibus_in[bank_idx_w-1:0];
         end
         // Only an OUT to the window wakes the registers up
         if (bank_wr.valid) begin
            dis <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // Bank registers
   ////////////////////////////////////////

   // Contents are undefined until written
   always_ff @(posedge clk) begin
      if (uwr_mbx) begin
         mb[act_idx] <= ibus_in;
      end
      // Later assignment wins, so APB beats the microcode on a clash
      if (bank_wr.valid) begin
         mb[bank_wr.idx] <= bank_wr.data;
      end
   end

   // I/O readback
   assign bank_rdata = mb[bank_rd.idx];

   ////////////////////////////////////////
   // Internal bus read of the pointer
   ////////////////////////////////////////

   assign ibus_oe  = strobe.read_mbp;
   assign ibus_out = strobe.read_mbp ? {{(bank_w-bank_idx_w){1'b0}}, mbp} : '0;

   ////////////////////////////////////////
   // Extended address
   ////////////////////////////////////////

   // While disabled, front-panel switch picks ROM or RAM base
   always_comb begin
      if (dis) begin
         aext = fprom ? default_rom : '0;
      end else begin
         aext = mb[act_idx];
      end
   end

endmodule : mbu_bank_file

`default_nettype wire

//--- verilog/mbu_bus_pkg.sv
////////////////////////////////////////
// Memory bank unit bus types: APB request
// and response, microcode strobes, and the
// bank file access records
////////////////////////////////////////

`default_nettype none

package mbu_bus_pkg;

   import mbu_pkg::*;

   // APB master to slave, one byte wide
   typedef struct packed {
      logic                 psel;
      logic                 penable;
      logic                 pwrite;
      logic [io_addr_w-1:0] paddr;
      logic [bank_w-1:0]    pwdata;
   } apb_req_t;

   // APB slave to master
   typedef struct packed {
      logic [bank_w-1:0] prdata;
      logic              pready;
      logic              pslverr;
   } apb_rsp_t;

   // Decoded micro-address strobes, ungated by wstb
   typedef struct packed {
      logic read_mbp;
      logic read_flags;
      logic write_mbp;
      logic write_flags;
      logic write_ar_mbx;
   } ucode_strobe_t;

   // Register write from I/O space, single cycle
   typedef struct packed {
      logic                  valid;
      logic [bank_idx_w-1:0] idx;
      logic [bank_w-1:0]     data;
   } bank_wr_t;

   // Readback select from I/O space
   typedef struct packed {
      logic [bank_idx_w-1:0] idx;
   } bank_rd_t;

endpackage : mbu_bus_pkg

`default_nettype wire

//--- verilog/mbu_io_port.sv
////////////////////////////////////////
// MBU I/O port. APB slave for the bank
// registers at I/O addresses 0x08..0x0F
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module mbu_io_port (
   input  logic                         clk,
   input  logic                         reset,
   input  mbu_bus_pkg::apb_req_t        apb_req,
   output mbu_bus_pkg::apb_rsp_t        apb_rsp,
   output mbu_bus_pkg::bank_wr_t        bank_wr,
   output mbu_bus_pkg::bank_rd_t        bank_rd,
   input  logic [mbu_pkg::bank_w-1:0]   bank_rdata
);

   import mbu_pkg::*;
   import mbu_bus_pkg::*;

   logic setup;
   logic access;
   logic hit;
   logic err_q;

   ////////////////////////////////////////
   // Phase and address decode
   ////////////////////////////////////////

   assign setup  = apb_req.psel & ~apb_req.penable;
   assign access = apb_req.psel & apb_req.penable;

   // Upper address bits select the window
   // Low bits index the register
   assign hit = (apb_req.paddr[io_addr_w-1:bank_idx_w] ==
                 io_base[io_addr_w-1:bank_idx_w]);

   // Error flag captured in setup, presented in access
   always_ff @(posedge clk) begin
      if (reset) begin
         err_q <= 1'b0;
      end else if (setup) begin
         err_q <= ~hit;
      end
   end

   ////////////////////////////////////////
   // Bank file requests
   ////////////////////////////////////////

   // One-cycle write, stored on the access-phase edge
   assign bank_wr.valid = access & apb_req.pwrite & hit;
   assign bank_wr.idx   = apb_req.paddr[bank_idx_w-1:0];
   assign bank_wr.data  = apb_req.pwdata;

   // Readback index, data returns combinationally
   assign bank_rd.idx = apb_req.paddr[bank_idx_w-1:0];

   ////////////////////////////////////////
   // APB response
   ////////////////////////////////////////

   // No wait states
   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access & err_q;
   // Misses read as zero
   assign apb_rsp.prdata  = (access & ~apb_req.pwrite & hit) ? bank_rdata : '0;

endmodule : mbu_io_port

`default_nettype wire

//--- verilog/mbu_pkg.sv
////////////////////////////////////////
// Memory bank unit register-file constants
// and microcode read/write address codes
////////////////////////////////////////

`default_nettype none

package mbu_pkg;

   ////////////////////////////////////////
   // Bank register file geometry
   ////////////////////////////////////////

   // Eight bank registers, fixed by the I/O map
   localparam int num_banks  = 8;
   localparam int bank_w     = 8;
   localparam int bank_idx_w = 3;

   // I/O space is byte addressed, low 8 bits only
   localparam int io_addr_w = 8;
   // Window 0x08..0x0F, aligned to num_banks
   localparam logic [io_addr_w-1:0] io_base = 8'h08;

   // Microcode address field width
   localparam int ucode_addr_w = 5;

   ////////////////////////////////////////
   // Microcode address codes
   ////////////////////////////////////////

   // Read side
   localparam logic [ucode_addr_w-1:0] raddr_mbp   = 5'b01100;
   localparam logic [ucode_addr_w-1:0] raddr_flags = 5'b01101;

   // Write side, symmetric to the read codes
   localparam logic [ucode_addr_w-1:0] waddr_mbp    = 5'b01100;
   localparam logic [ucode_addr_w-1:0] waddr_flags  = 5'b01101;
   localparam logic [ucode_addr_w-1:0] waddr_ar_mbx = 5'b01110;

   // Extended address before the first OUT, switch in ROM position
   localparam logic [bank_w-1:0] default_rom = 8'h80;

endpackage : mbu_pkg

`default_nettype wire

//--- verilog/mbu_top.sv
////////////////////////////////////////
// Memory bank unit top level. Microcode
// decoder, I/O port and bank file
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module mbu_top (
   input  logic                             clk,
   input  logic                             reset,
   input  mbu_bus_pkg::apb_req_t            apb_req,
   output mbu_bus_pkg::apb_rsp_t            apb_rsp,
   input  logic [mbu_pkg::ucode_addr_w-1:0] raddr,
   input  logic [mbu_pkg::ucode_addr_w-1:0] waddr,
   input  logic                             wstb,
   input  logic [11:0]                      ir,
   input  logic [mbu_pkg::bank_w-1:0]       ibus_in,
   output logic [mbu_pkg::bank_w-1:0]       ibus_out,
   output logic                             ibus_oe,
   input  logic                             fprom,
   output logic [mbu_pkg::bank_w-1:0]       aext,
   output logic                             read_flags,
   output logic                             write_flags
);

   import mbu_pkg::*;
   import mbu_bus_pkg::*;

   ucode_strobe_t     strobe;
   bank_wr_t          bank_wr;
   bank_rd_t          bank_rd;
   logic [bank_w-1:0] bank_rdata;

   // Microcode side
   mbu_ucode_decode ucode_decode_i (
      .raddr       (raddr),
      .waddr       (waddr),
      .wstb        (wstb),
      .strobe      (strobe),
      .write_flags (write_flags)
   );

   // Flag unit read strobe goes straight out
   assign read_flags = strobe.read_flags;

   // I/O side
   mbu_io_port io_port_i (
      .clk        (clk),
      .reset      (reset),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .bank_wr    (bank_wr),
      .bank_rd    (bank_rd),
      .bank_rdata (bank_rdata)
   );

   mbu_bank_file bank_file_i (
      .clk        (clk),
      .reset      (reset),
      .wstb       (wstb),
      .strobe     (strobe),
      .bank_wr    (bank_wr),
      .bank_rd    (bank_rd),
      .bank_rdata (bank_rdata),
      .ir         (ir),
      .ibus_in    (ibus_in),
      .ibus_out   (ibus_out),
      .ibus_oe    (ibus_oe),
      .fprom      (fprom),
      .aext       (aext)
   );

endmodule : mbu_top

`default_nettype wire

//--- verilog/mbu_ucode_decode.sv
////////////////////////////////////////
// Microcode address decoder for the MBU.
// Turns RADDR/WADDR into unit strobes.
////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module mbu_ucode_decode (
   input  logic [mbu_pkg::ucode_addr_w-1:0] raddr,
   input  logic [mbu_pkg::ucode_addr_w-1:0] waddr,
   input  logic                             wstb,
   output mbu_bus_pkg::ucode_strobe_t       strobe,
   output logic                             write_flags
);

   import mbu_pkg::*;
   import mbu_bus_pkg::*;

   ////////////////////////////////////////
   // Read address decode
   ////////////////////////////////////////

   // Bank pointer onto the internal bus
   assign strobe.read_mbp   = (raddr == raddr_mbp);
   // Flag unit read, passed straight out
   assign strobe.read_flags = (raddr == raddr_flags);

   ////////////////////////////////////////
   // Write address decode
   ////////////////////////////////////////

   // These stay ungated
   // The bank file samples them with wstb on the clock edge
   assign strobe.write_mbp    = (waddr == waddr_mbp);
   assign strobe.write_flags  = (waddr == waddr_flags);
   assign strobe.write_ar_mbx = (waddr == waddr_ar_mbx);

   // External flag unit write
   // Qualified here because it leaves the unit as a strobe
   assign write_flags = strobe.write_flags & wstb;

endmodule : mbu_ucode_decode

`default_nettype wire
